// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= if_stage_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
HEX ?= bench/prog.hex
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	cp $(HEX) prog.hex
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG) prog.hex

// ==== bench/if_stage_tb.sv ====
`timescale 1ns/1ps

module if_stage_tb;

  // one stimulus row
  typedef struct packed {
    logic use_hold;
    logic [7:0] hold_len;
    logic do_redirect;
    logic [31:0] target;
    logic [7:0] n_inst;
    logic expect_none;
  } row_t;

  logic clk;
  logic rst_n;
  logic hold_i;
  logic redirect_i;
  logic [31:0] redirect_pc_i;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic inst_valid_o;

  // private copy of the program image
  logic [31:0] model_rom [if_pkg::ROM_DEPTH];
  row_t rows [8];
  logic [31:0] exp_pc;
  logic table_ready;
  integer seed;
  int errors;
  int checked;
  int row_valids;

  if_stage dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .hold_i        (hold_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .inst_valid_o  (inst_valid_o)
  );

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // cycles an out of range row waits for a stray instruction
  function automatic int none_window();
    return 8 * (if_pkg::ROM_LAT + 6);
  endfunction

  // static prediction, jal taken and everything else falls through
  function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] word);
    logic [31:0] imm;
    imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    if (word[6:0] == if_pkg::OPC_JAL) begin
      return pc + imm;
    end
    return pc + 32'd4;
  endfunction

  function automatic row_t make_row(input logic use_hold, input logic do_redirect,
                                    input logic [31:0] target, input logic [7:0] n_inst,
                                    input logic expect_none);
    row_t row;
    row.use_hold = use_hold;
    row.hold_len = 8'd0;
    row.do_redirect = do_redirect;
    row.target = target;
    row.n_inst = n_inst;
    row.expect_none = expect_none;
    return row;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("failure at %0t ns: %s", $time, what);
  endtask

  task automatic build_table();
    // straight code into the first jal
    rows[0] = make_row(1'b0, 1'b0, 32'h0, 8'd10, 1'b0);
    rows[1] = make_row(1'b1, 1'b0, 32'h0, 8'd8, 1'b0);
    rows[2] = make_row(1'b0, 1'b1, 32'h20, 8'd6, 1'b0);
    // runs into the backward jal
    rows[3] = make_row(1'b1, 1'b1, 32'h44, 8'd12, 1'b0);
    // beyond the rom, errors only
    rows[4] = make_row(1'b0, 1'b1, 32'h200, 8'd0, 1'b1);
    rows[5] = make_row(1'b0, 1'b1, 32'h0C, 8'd6, 1'b0);
    rows[6] = make_row(1'b1, 1'b0, 32'h0, 8'd14, 1'b0);
    rows[7] = make_row(1'b1, 1'b1, 32'h58, 8'd5, 1'b0);
    for (int r = 0; r < $size(rows); r++) begin
      if (rows[r].use_hold) begin
        // spans at least two fetch periods, so a leaking hold shows a second word
        rows[r].hold_len = 8'(2 * (if_pkg::ROM_LAT + 4) + ($unsigned($random(seed)) % 16));
      end
    end
  endtask

  // compare one cycle of outputs with the model
  task automatic observe();
    logic [31:0] word;
    if (inst_valid_o === 1'b1) begin
      row_valids++;
      checked++;
      if (exp_pc[31:2] >= 30'(if_pkg::ROM_DEPTH)) begin
        note_failure("an instruction appeared while the pc was beyond the rom");
      end else begin
        word = model_rom[exp_pc[if_pkg::ROM_AW+1:2]];
        compare("pc_o", pc_o, exp_pc);
        compare("inst_o", inst_o, word);
        exp_pc = next_pc(exp_pc, word);
      end
    end else begin
      // bubble between valid words
      compare("inst_o", inst_o, if_pkg::NOP_INST);
    end
  endtask

  // drive on the rising edge, sample at the falling edge
  task automatic tick(input logic hold, input logic redir, input logic [31:0] tgt);
    @(posedge clk);
    hold_i <= hold;
    redirect_i <= redir;
    redirect_pc_i <= tgt;
    @(negedge clk);
    observe();
    // word seen in the redirect cycle still belongs to the old path
    if (redir) begin
      exp_pc = tgt;
    end
  endtask

  task automatic run_row(input int r);
    int err_before;
    int chk_before;
    err_before = errors;
    chk_before = checked;
    // lands while the next fetch is in flight
    if (rows[r].do_redirect) begin
      tick(1'b0, 1'b1, rows[r].target);
    end
    if (rows[r].use_hold) begin
      row_valids = 0;
      repeat (int'(rows[r].hold_len)) tick(1'b1, 1'b0, 32'd0);
      if (row_valids > 1) begin
        note_failure("more than one instruction appeared while hold was high");
      end
    end
    if (rows[r].expect_none) begin
      repeat (none_window()) tick(1'b0, 1'b0, 32'd0);
    end
    row_valids = 0;
    while (row_valids < int'(rows[r].n_inst)) begin
      tick(1'b0, 1'b0, 32'd0);
    end
    $display("row %0d: hold %0d, %0d instructions checked, %0d errors", r,
             rows[r].hold_len, checked - chk_before, errors - err_before);
  endtask

  initial begin
    seed = 32'h2854fb2d;
    errors = 0;
    checked = 0;
    row_valids = 0;
    table_ready = 1'b0;
    exp_pc = if_pkg::RESET_PC;
    rst_n <= 1'b0;
    hold_i <= 1'b0;
    redirect_i <= 1'b0;
    redirect_pc_i <= 32'd0;
    $readmemh("bench/prog.hex", model_rom);
    build_table();
    table_ready = 1'b1;
    // outputs quiet throughout reset
    repeat (16) begin
      @(negedge clk);
      compare("inst_valid_o", 32'(inst_valid_o), 32'd0);
      compare("inst_o", inst_o, if_pkg::NOP_INST);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    for (int r = 0; r < $size(rows); r++) begin
      run_row(r);
    end
    $display("rows %0d, instructions %0d, errors %0d", $size(rows), checked, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // budget from the table, per instruction plus hold and idle windows
  initial begin
    int limit;
    wait (table_ready === 1'b1);
    limit = 16 + 200;
    for (int r = 0; r < $size(rows); r++) begin
      limit += int'(rows[r].n_inst) * (if_pkg::ROM_LAT + 6);
      limit += int'(rows[r].hold_len);
      if (rows[r].do_redirect) begin
        limit += 2 * (if_pkg::ROM_LAT + 6);
      end
      if (rows[r].expect_none) begin
        limit += none_window();
      end
    end
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== bench/prog.hex ====
// one 32-bit instruction word per line in hex
// line n holds word index n at byte address 4*n
00100093
00200113
00300193
00400213
00500293
00600313
0200006F
00800413
00900493
00A00513
00B00593
00C00613
00D00693
00E00713
00F00793
01000813
020000EF
01100893
01200913
01300993
01400A13
01500A93
01600B13
01700B93
01800C13
01900C93
01A00D13
F95FF06F
01C00E13
01D00E93
01E00F13
01F00F93

// ==== build.f ====
rtl/if_pkg.sv
rtl/fetch_ctrl.sv
rtl/pc_gen.sv
rtl/axi_rd_master.sv
rtl/inst_rom_slave.sv
rtl/inst_select.sv
rtl/if_stage.sv
bench/if_stage_tb.sv

// ==== rtl/axi_rd_master.sv ====
`timescale 1ns/1ps

module axi_rd_master (
  input  logic clk,
  input  logic rst_n,
  input  logic fetch_go_i,
  input  logic [if_pkg::XLEN-1:0] addr_i,
  output if_pkg::ar_chan_t ar_o,
  input  logic ar_ready_i,
  input  if_pkg::r_chan_t r_i,
  output logic r_ready_o,
  output if_pkg::fetch_rsp_t rsp_o
);

  logic [1:0] state_q;
  logic [if_pkg::XLEN-1:0] addr_q;
  logic [if_pkg::XLEN-1:0] data_q;
  logic err_q;
  logic done_q;
  logic r_fire;

  // single beat only
  assign r_fire = r_i.valid && r_ready_o;

  // address stays put until the slave takes it
  assign ar_o.valid = (state_q == if_pkg::MS_ADDR);
  assign ar_o.addr = addr_q;

  // always ready while waiting, no back-pressure on r
  assign r_ready_o = (state_q == if_pkg::MS_DATA);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= if_pkg::MS_IDLE;
      done_q <= 1'b0;
    end else begin
      // done is a one-cycle pulse
      done_q <= 1'b0;
      case (state_q)
        if_pkg::MS_IDLE: begin
          if (fetch_go_i) begin
            state_q <= if_pkg::MS_ADDR;
          end
        end
        if_pkg::MS_ADDR: begin
          if (ar_ready_i) begin
            state_q <= if_pkg::MS_DATA;
          end
        end
        if_pkg::MS_DATA: begin
          if (r_fire) begin
            done_q <= 1'b1;
            state_q <= if_pkg::MS_IDLE;
          end
        end
        default: begin
          state_q <= if_pkg::MS_IDLE;
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    // capture fetch address at launch
    if (state_q == if_pkg::MS_IDLE && fetch_go_i) begin
      addr_q <= addr_i;
    end
    // capture beat and flag any non-okay response
    if (r_fire) begin
      data_q <= r_i.data;
      err_q <= (r_i.resp != if_pkg::RESP_OKAY);
    end
  end

  assign rsp_o.done = done_q;
  assign rsp_o.err = err_q;
  assign rsp_o.data = data_q;

endmodule

// ==== rtl/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic hold_i,
  input  logic redirect_i,
  input  if_pkg::fetch_rsp_t rsp_i,
  output logic fetch_go_o,
  output logic accept_o
);

  logic [1:0] state_q;
  // set when the word in flight belongs to a stale pc
  logic discard_q;
  logic rsp_ok;

  // good word for the current pc
  // a redirect in the same cycle as done also kills it
  assign rsp_ok = rsp_i.done && !rsp_i.err && !discard_q && !redirect_i;

  // accept only while a fetch is outstanding
  assign accept_o = (state_q == if_pkg::FC_BUSY) && rsp_ok;

  // launch from idle only
  // hold blocks new fetches
  // redirect delays by one cycle so the master sees the new pc
  assign fetch_go_o = (state_q == if_pkg::FC_IDLE) && !hold_i && !redirect_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // quiet cycle out of reset before the first fetch
      state_q <= if_pkg::FC_SETTLE;
      discard_q <= 1'b0;
    end else begin
      case (state_q)
        if_pkg::FC_IDLE: begin
          if (fetch_go_o) begin
            state_q <= if_pkg::FC_BUSY;
          end
        end
        if_pkg::FC_BUSY: begin
          if (rsp_i.done) begin
            // fetch over, flag no longer needed
            discard_q <= 1'b0;
            // accepted word lets the next fetch go right away
            // dropped or errored word takes one settle cycle
            if (rsp_ok) begin
              state_q <= if_pkg::FC_IDLE;
            end else begin
              state_q <= if_pkg::FC_SETTLE;
            end
          end else if (redirect_i) begin
            // returning word is from the old path
            discard_q <= 1'b1;
          end
        end
        if_pkg::FC_SETTLE: begin
          // pc unchanged on error so the retry hits the same address
          state_q <= if_pkg::FC_IDLE;
        end
        default: begin
          state_q <= if_pkg::FC_SETTLE;
          discard_q <= 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== rtl/if_pkg.sv ====
package if_pkg;

  // address and instruction width
  localparam int XLEN = 32;

  // first fetch address out of reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // rom geometry in words
  localparam int ROM_DEPTH = 32;
  localparam int ROM_AW = $clog2(ROM_DEPTH);

  // cycles from ar acceptance to r valid
  localparam int ROM_LAT = 2;
  localparam int LAT_W = $clog2(ROM_LAT + 1);
  // last count value before the response goes out
  localparam logic [LAT_W-1:0] LAT_LAST = LAT_W'(ROM_LAT - 1);

  // addi x0,x0,0 used as bubble
  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;
  localparam logic [6:0] OPC_JAL = 7'b110_1111;

  // axi response codes
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // fetch controller states
  localparam logic [1:0] FC_IDLE = 2'd0;
  localparam logic [1:0] FC_BUSY = 2'd1;
  localparam logic [1:0] FC_SETTLE = 2'd2;

  // read master states
  localparam logic [1:0] MS_IDLE = 2'd0;
  localparam logic [1:0] MS_ADDR = 2'd1;
  localparam logic [1:0] MS_DATA = 2'd2;

  // rom slave states
  localparam logic [1:0] SL_IDLE = 2'd0;
  localparam logic [1:0] SL_WAIT = 2'd1;
  localparam logic [1:0] SL_RESP = 2'd2;

  // read address channel, master to slave
  typedef struct packed {
    logic valid;
    logic [XLEN-1:0] addr;
  } ar_chan_t;

  // read data channel, slave to master
  typedef struct packed {
    logic valid;
    logic [XLEN-1:0] data;
    logic [1:0] resp;
    logic last;
  } r_chan_t;

  // completed fetch as seen by control and datapath
  typedef struct packed {
    logic done;
    logic err;
    logic [XLEN-1:0] data;
  } fetch_rsp_t;

  // j-type field layout
  typedef struct packed {
    logic imm_20;
    logic [9:0] imm_10_1;
    logic imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fields_t;

  // same word seen raw or as jal fields
  typedef union packed {
    logic [XLEN-1:0] raw;
    j_fields_t j;
  } inst_word_u;

endpackage

// ==== rtl/if_stage.sv ====
`timescale 1ns/1ps

module if_stage (
  input  logic clk,
  input  logic rst_n,
  input  logic hold_i,
  input  logic redirect_i,
  input  logic [if_pkg::XLEN-1:0] redirect_pc_i,
  output logic [if_pkg::XLEN-1:0] inst_o,
  output logic [if_pkg::XLEN-1:0] pc_o,
  output logic inst_valid_o
);

  // control strobes
  logic fetch_go;
  logic accept;

  // fetch address from the pc register
  logic [if_pkg::XLEN-1:0] fetch_pc;

  // completed fetch back from the master
  if_pkg::fetch_rsp_t fetch_rsp;

  // axi read channels between master and rom
  if_pkg::ar_chan_t ar_chan;
  if_pkg::r_chan_t r_chan;
  logic ar_ready;
  logic r_ready;

  fetch_ctrl u_fetch_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .hold_i     (hold_i),
    .redirect_i (redirect_i),
    .rsp_i      (fetch_rsp),
    .fetch_go_o (fetch_go),
    .accept_o   (accept)
  );

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .accept_i      (accept),
    .rsp_i         (fetch_rsp),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (fetch_pc)
  );

  axi_rd_master u_axi_rd_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_go_i (fetch_go),
    .addr_i     (fetch_pc),
    .ar_o       (ar_chan),
    .ar_ready_i (ar_ready),
    .r_i        (r_chan),
    .r_ready_o  (r_ready),
    .rsp_o      (fetch_rsp)
  );

  inst_rom_slave u_inst_rom_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_i       (ar_chan),
    .ar_ready_o (ar_ready),
    .r_o        (r_chan),
    .r_ready_i  (r_ready)
  );

  inst_select u_inst_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .accept_i     (accept),
    .rsp_i        (fetch_rsp),
    .pc_i         (fetch_pc),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .inst_valid_o (inst_valid_o)
  );

endmodule

// ==== rtl/inst_rom_slave.sv ====
`timescale 1ns/1ps

module inst_rom_slave (
  input  logic clk,
  input  logic rst_n,
  input  if_pkg::ar_chan_t ar_i,
  output logic ar_ready_o,
  output if_pkg::r_chan_t r_o,
  input  logic r_ready_i
);

  logic [if_pkg::XLEN-1:0] rom [if_pkg::ROM_DEPTH];
  logic [1:0] state_q;
  logic [if_pkg::LAT_W-1:0] lat_cnt_q;
  logic [if_pkg::XLEN-1:0] data_q;
  logic [1:0] resp_q;
  logic [if_pkg::XLEN-3:0] word_idx;
  logic oob;
  logic ar_fire;

  // program image
  initial begin
    $readmemh("prog.hex", rom);
  end

  assign ar_fire = ar_i.valid && ar_ready_o;

  // byte address to word index
  assign word_idx = ar_i.addr[if_pkg::XLEN-1:2];
  assign oob = (word_idx >= (if_pkg::XLEN-2)'(if_pkg::ROM_DEPTH));

  // one request at a time, ready only in idle
  assign ar_ready_o = (state_q == if_pkg::SL_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= if_pkg::SL_IDLE;
      lat_cnt_q <= '0;
    end else begin
      case (state_q)
        if_pkg::SL_IDLE: begin
          if (ar_fire) begin
            lat_cnt_q <= '0;
            state_q <= if_pkg::SL_WAIT;
          end
        end
        if_pkg::SL_WAIT: begin
          // count out the fixed access latency
          lat_cnt_q <= lat_cnt_q + 1'b1;
          if (lat_cnt_q == if_pkg::LAT_LAST) begin
            state_q <= if_pkg::SL_RESP;
          end
        end
        if_pkg::SL_RESP: begin
          // response held until the master takes it
          if (r_ready_i) begin
            state_q <= if_pkg::SL_IDLE;
          end
        end
        default: begin
          state_q <= if_pkg::SL_IDLE;
        end
      endcase
    end
  end

  // read at acceptance, held through the wait
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      if (oob) begin
        data_q <= '0;
        resp_q <= if_pkg::RESP_SLVERR;
      end else begin
        data_q <= rom[ar_i.addr[if_pkg::ROM_AW+1:2]];
        resp_q <= if_pkg::RESP_OKAY;
      end
    end
  end

  assign r_o.valid = (state_q == if_pkg::SL_RESP);
  assign r_o.data = data_q;
  assign r_o.resp = resp_q;
  // single beat bursts only
  assign r_o.last = 1'b1;

endmodule

// ==== rtl/inst_select.sv ====
`timescale 1ns/1ps

module inst_select (
  input  logic clk,
  input  logic rst_n,
  input  logic accept_i,
  input  if_pkg::fetch_rsp_t rsp_i,
  input  logic [if_pkg::XLEN-1:0] pc_i,
  output logic [if_pkg::XLEN-1:0] inst_o,
  output logic [if_pkg::XLEN-1:0] pc_o,
  output logic inst_valid_o
);

  logic [if_pkg::XLEN-1:0] inst_q;
  logic [if_pkg::XLEN-1:0] pc_q;
  logic valid_q;

  // valid lasts exactly one cycle per accept
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      pc_q <= if_pkg::RESET_PC;
    end else begin
      valid_q <= accept_i;
      // pc of the accepted word, kept between accepts
      if (accept_i) begin
        pc_q <= pc_i;
      end
    end
  end

  // instruction word itself
  always_ff @(posedge clk) begin
    if (accept_i) begin
      inst_q <= rsp_i.data;
    end
  end

  // bubble whenever nothing new is presented
  assign inst_o = valid_q ? inst_q : if_pkg::NOP_INST;
  assign pc_o = pc_q;
  assign inst_valid_o = valid_q;

endmodule

// ==== rtl/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic accept_i,
  input  if_pkg::fetch_rsp_t rsp_i,
  input  logic redirect_i,
  input  logic [if_pkg::XLEN-1:0] redirect_pc_i,
  output logic [if_pkg::XLEN-1:0] pc_o
);

  logic [if_pkg::XLEN-1:0] pc_q;
  logic [if_pkg::XLEN-1:0] jal_imm;
  logic [if_pkg::XLEN-1:0] pc_step;
  if_pkg::inst_word_u fetched;

  // returned word decoded as j-type
  assign fetched.raw = rsp_i.data;

  // sign-extended jal offset, bit 0 always zero
  assign jal_imm = {{11{fetched.j.imm_20}}, fetched.j.imm_20, fetched.j.imm_19_12,
                    fetched.j.imm_11, fetched.j.imm_10_1, 1'b0};

  // static prediction
  // jal is taken, everything else falls through
  assign pc_step = (fetched.j.opcode == if_pkg::OPC_JAL) ? jal_imm : 32'd4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= if_pkg::RESET_PC;
    end else if (redirect_i) begin
      // late resolved branch overrides prediction
      pc_q <= redirect_pc_i;
    end else if (accept_i) begin
      pc_q <= pc_q + pc_step;
    end
  end

  // current pc doubles as fetch address
  assign pc_o = pc_q;

endmodule
